/* tile_pkg.sv */
package tile_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  parameter int XLEN = 32;
  parameter int RD_W = 5;

  // Commit id field of the shared structs is sized for a 256-entry ROB
  // Modules narrow it to their own CMT_ID_W
  parameter int CMT_ID_MAX_W = 8;

  // ------------------------------
  // Encodings
  // ------------------------------
  typedef enum logic [3:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_AND = 4'd2,
    OP_OR  = 4'd3,
    OP_XOR = 4'd4,
    OP_SLT = 4'd5,
    OP_SLL = 4'd6,
    OP_MUL = 4'd7
  } op_t;

  typedef enum logic {
    CAT_ARITH = 1'b0,
    CAT_MUL   = 1'b1
  } inst_cat_t;

  // ------------------------------
  // Payloads
  // ------------------------------
  // Instruction on its way to a unit
  typedef struct packed {
    logic [CMT_ID_MAX_W-1:0] cmt_id;
    op_t                     op;
    logic [RD_W-1:0]         rd;
    logic [XLEN-1:0]         src1;
    logic [XLEN-1:0]         src2;
  } issue_t;

  // Completion report towards the ROB
  typedef struct packed {
    logic [CMT_ID_MAX_W-1:0] cmt_id;
    logic [RD_W-1:0]         rd;
    logic [XLEN-1:0]         data;
  } done_rpt_t;

endpackage

/* stage_pipe.sv */
module stage_pipe #(
  parameter type T     = logic,
  parameter int  DEPTH = 1
) (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_valid,
  input  T     i_data,
  output logic o_valid,
  output T     o_data
);

  logic [DEPTH-1:0] r_valid;
  T                 r_data [DEPTH];

  // Valid chain
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_valid <= '0;
    end else begin
      r_valid[0] <= i_valid;
      for (int i = 1; i < DEPTH; i++) begin
        r_valid[i] <= r_valid[i-1];
      end
    end
  end

  // Payload only moves with a valid item
  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      r_data[0] <= i_data;
    end
    for (int i = 1; i < DEPTH; i++) begin
      if (r_valid[i-1]) begin
        r_data[i] <= r_data[i-1];
      end
    end
  end

  assign o_valid = r_valid[DEPTH-1];
  assign o_data  = r_data[DEPTH-1];

endmodule

/* disp_steer.sv */
module disp_steer import tile_pkg::*; #(
  parameter int CMT_ID_W = 4
) (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_disp_valid,
  input  op_t                 i_disp_op,
  input  logic [RD_W-1:0]     i_disp_rd,
  input  logic [XLEN-1:0]     i_disp_src1,
  input  logic [XLEN-1:0]     i_disp_src2,
  input  logic [CMT_ID_W-1:0] i_new_cmt_id,
  output logic                o_alloc_valid,
  output logic                o_alu_valid,
  output logic [CMT_ID_W-1:0] o_alu_cmt_id,
  output logic [RD_W-1:0]     o_alu_rd,
  output op_t                 o_alu_op,
  output logic [XLEN-1:0]     o_alu_src1,
  output logic [XLEN-1:0]     o_alu_src2,
  output logic                o_mul_valid,
  output logic [CMT_ID_W-1:0] o_mul_cmt_id,
  output logic [RD_W-1:0]     o_mul_rd,
  output logic [XLEN-1:0]     o_mul_src1,
  output logic [XLEN-1:0]     o_mul_src2
);

  issue_t    w_disp_in;
  issue_t    w_cur;
  logic      w_cur_valid;
  inst_cat_t w_cat;

  // Commit id is not known yet at dispatch
  assign w_disp_in.cmt_id = '0;
  assign w_disp_in.op     = i_disp_op;
  assign w_disp_in.rd     = i_disp_rd;
  assign w_disp_in.src1   = i_disp_src1;
  assign w_disp_in.src2   = i_disp_src2;

  stage_pipe #(.T(issue_t), .DEPTH(1)) u_disp_stage (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (i_disp_valid),
    .i_data  (w_disp_in),
    .o_valid (w_cur_valid),
    .o_data  (w_cur)
  );

  assign w_cat = (w_cur.op == OP_MUL) ? CAT_MUL : CAT_ARITH;

  // One ROB entry per registered instruction
  assign o_alloc_valid = w_cur_valid;

  // ------------------------------
  // Issue to units
  // ------------------------------
  assign o_alu_valid  = w_cur_valid && (w_cat == CAT_ARITH);
  assign o_alu_cmt_id = i_new_cmt_id;
  assign o_alu_rd     = w_cur.rd;
  assign o_alu_op     = w_cur.op;
  assign o_alu_src1   = w_cur.src1;
  assign o_alu_src2   = w_cur.src2;

  assign o_mul_valid  = w_cur_valid && (w_cat == CAT_MUL);
  assign o_mul_cmt_id = i_new_cmt_id;
  assign o_mul_rd     = w_cur.rd;
  assign o_mul_src1   = w_cur.src1;
  assign o_mul_src2   = w_cur.src2;

  // A registered dispatch reaches exactly one unit
  a_one_unit: assert property (@(posedge i_clk) disable iff (i_rst)
    i_disp_valid |=> (o_alu_valid != o_mul_valid))
    else $error("Dispatch not issued to exactly one unit");

endmodule

/* alu_unit.sv */
module alu_unit import tile_pkg::*; #(
  parameter int CMT_ID_W = 4
) (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_valid,
  input  logic [CMT_ID_W-1:0] i_cmt_id,
  input  logic [RD_W-1:0]     i_rd,
  input  op_t                 i_op,
  input  logic [XLEN-1:0]     i_src1,
  input  logic [XLEN-1:0]     i_src2,
  output logic                o_done_valid,
  output logic [CMT_ID_W-1:0] o_done_cmt_id,
  output logic [RD_W-1:0]     o_done_rd,
  output logic [XLEN-1:0]     o_done_data
);

  logic [XLEN-1:0] w_result;
  logic            w_lt;
  done_rpt_t       w_rpt_in;
  done_rpt_t       w_rpt_out;

  assign w_lt = $signed(i_src1) < $signed(i_src2);

  // ------------------------------
  // Execute
  // ------------------------------
  always_comb begin
    case (i_op)
      OP_ADD:  w_result = i_src1 + i_src2;
      OP_SUB:  w_result = i_src1 - i_src2;
      OP_AND:  w_result = i_src1 & i_src2;
      OP_OR:   w_result = i_src1 | i_src2;
      OP_XOR:  w_result = i_src1 ^ i_src2;
      OP_SLT:  w_result = {{(XLEN-1){1'b0}}, w_lt};
      // Shift amount is the low five bits only
      OP_SLL:  w_result = i_src1 << i_src2[4:0];
      default: w_result = '0;
    endcase
  end

  assign w_rpt_in.cmt_id = CMT_ID_MAX_W'(i_cmt_id);
  assign w_rpt_in.rd     = i_rd;
  assign w_rpt_in.data   = w_result;

  stage_pipe #(.T(done_rpt_t), .DEPTH(1)) u_done_stage (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (i_valid),
    .i_data  (w_rpt_in),
    .o_valid (o_done_valid),
    .o_data  (w_rpt_out)
  );

  assign o_done_cmt_id = w_rpt_out.cmt_id[CMT_ID_W-1:0];
  assign o_done_rd     = w_rpt_out.rd;
  assign o_done_data   = w_rpt_out.data;

  // Steering must keep multiplies away from here
  a_no_mul: assert property (@(posedge i_clk) disable iff (i_rst)
    i_valid |-> (i_op != OP_MUL))
    else $error("Multiply issued to the ALU");

endmodule

/* mul_unit.sv */
module mul_unit import tile_pkg::*; #(
  parameter int CMT_ID_W = 4
) (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_valid,
  input  logic [CMT_ID_W-1:0] i_cmt_id,
  input  logic [RD_W-1:0]     i_rd,
  input  logic [XLEN-1:0]     i_src1,
  input  logic [XLEN-1:0]     i_src2,
  output logic                o_done_valid,
  output logic [CMT_ID_W-1:0] o_done_cmt_id,
  output logic [RD_W-1:0]     o_done_rd,
  output logic [XLEN-1:0]     o_done_data
);

  issue_t          w_opnd_in;
  issue_t          w_s1;
  logic            w_s1_valid;
  logic [XLEN-1:0] w_prod;
  done_rpt_t       w_rpt_in;
  done_rpt_t       w_rpt_out;

  // ------------------------------
  // Stage 1 operands
  // ------------------------------
  assign w_opnd_in.cmt_id = CMT_ID_MAX_W'(i_cmt_id);
  assign w_opnd_in.op     = OP_MUL;
  assign w_opnd_in.rd     = i_rd;
  assign w_opnd_in.src1   = i_src1;
  assign w_opnd_in.src2   = i_src2;

  stage_pipe #(.T(issue_t), .DEPTH(1)) u_opnd_stage (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (i_valid),
    .i_data  (w_opnd_in),
    .o_valid (w_s1_valid),
    .o_data  (w_s1)
  );

  // Low half of the product only
  assign w_prod = w_s1.src1 * w_s1.src2;

  // ------------------------------
  // Stages 2 and 3
  // ------------------------------
  assign w_rpt_in.cmt_id = w_s1.cmt_id;
  assign w_rpt_in.rd     = w_s1.rd;
  assign w_rpt_in.data   = w_prod;

  stage_pipe #(.T(done_rpt_t), .DEPTH(2)) u_prod_stage (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (w_s1_valid),
    .i_data  (w_rpt_in),
    .o_valid (o_done_valid),
    .o_data  (w_rpt_out)
  );

  assign o_done_cmt_id = w_rpt_out.cmt_id[CMT_ID_W-1:0];
  assign o_done_rd     = w_rpt_out.rd;
  assign o_done_data   = w_rpt_out.data;

endmodule

/* rob.sv */
module rob import tile_pkg::*; #(
  parameter int ROB_DEPTH = 16,
  parameter int CMT_ID_W  = 4
) (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_alloc_valid,
  output logic [CMT_ID_W-1:0] o_new_cmt_id,
  input  logic                i_done_a_valid,
  input  logic [CMT_ID_W-1:0] i_done_a_cmt_id,
  input  logic [RD_W-1:0]     i_done_a_rd,
  input  logic [XLEN-1:0]     i_done_a_data,
  input  logic                i_done_b_valid,
  input  logic [CMT_ID_W-1:0] i_done_b_cmt_id,
  input  logic [RD_W-1:0]     i_done_b_rd,
  input  logic [XLEN-1:0]     i_done_b_data,
  output logic                o_cmt_valid,
  output logic [RD_W-1:0]     o_cmt_rd,
  output logic [XLEN-1:0]     o_cmt_data
);

  logic [ROB_DEPTH-1:0] r_valid;
  logic [ROB_DEPTH-1:0] r_done;
  logic [RD_W-1:0]      r_rd   [ROB_DEPTH];
  logic [XLEN-1:0]      r_data [ROB_DEPTH];
  logic [CMT_ID_W-1:0]  r_head;
  logic [CMT_ID_W-1:0]  r_tail;

  logic                 w_hit_a;
  logic                 w_hit_b;
  logic                 w_commit;
  logic [RD_W-1:0]      w_head_rd;
  logic [XLEN-1:0]      w_head_data;

  assign o_new_cmt_id = r_tail;

  // ------------------------------
  // Head selection
  // ------------------------------
  // A report for the head entry can retire in the cycle it arrives
  assign w_hit_a = i_done_a_valid && (i_done_a_cmt_id == r_head);
  assign w_hit_b = i_done_b_valid && (i_done_b_cmt_id == r_head);

  always_comb begin
    if (r_done[r_head]) begin
      w_head_rd   = r_rd[r_head];
      w_head_data = r_data[r_head];
    end else if (w_hit_a) begin
      w_head_rd   = i_done_a_rd;
      w_head_data = i_done_a_data;
    end else begin
      w_head_rd   = i_done_b_rd;
      w_head_data = i_done_b_data;
    end
  end

  assign w_commit = r_valid[r_head] && (r_done[r_head] || w_hit_a || w_hit_b);

  // Pointers wrap on their own since depth is a power of two
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_head <= '0;
      r_tail <= '0;
    end else begin
      if (i_alloc_valid) begin
        r_tail <= r_tail + 1'b1;
      end
      if (w_commit) begin
        r_head <= r_head + 1'b1;
      end
    end
  end

  // Freeing at commit wins over a done in the same cycle
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_valid <= '0;
      r_done  <= '0;
    end else begin
      if (i_alloc_valid) begin
        r_valid[r_tail] <= 1'b1;
      end
      if (i_done_a_valid) begin
        r_done[i_done_a_cmt_id] <= 1'b1;
      end
      if (i_done_b_valid) begin
        r_done[i_done_b_cmt_id] <= 1'b1;
      end
      if (w_commit) begin
        r_valid[r_head] <= 1'b0;
        r_done[r_head]  <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_done_a_valid) begin
      r_rd[i_done_a_cmt_id]   <= i_done_a_rd;
      r_data[i_done_a_cmt_id] <= i_done_a_data;
    end
    if (i_done_b_valid) begin
      r_rd[i_done_b_cmt_id]   <= i_done_b_rd;
      r_data[i_done_b_cmt_id] <= i_done_b_data;
    end
  end

  // ------------------------------
  // Commit output
  // ------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_cmt_valid <= 1'b0;
    end else begin
      o_cmt_valid <= w_commit;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_commit) begin
      o_cmt_rd   <= w_head_rd;
      o_cmt_data <= w_head_data;
    end
  end

  a_no_overflow: assert property (@(posedge i_clk) disable iff (i_rst)
    i_alloc_valid |-> !r_valid[r_tail])
    else $error("Allocation into a full ROB");

  a_done_a_live: assert property (@(posedge i_clk) disable iff (i_rst)
    i_done_a_valid |-> (r_valid[i_done_a_cmt_id] && !r_done[i_done_a_cmt_id]))
    else $error("ALU report for a free or finished entry");

  a_done_b_live: assert property (@(posedge i_clk) disable iff (i_rst)
    i_done_b_valid |-> (r_valid[i_done_b_cmt_id] && !r_done[i_done_b_cmt_id]))
    else $error("Multiplier report for a free or finished entry");

endmodule

/* exec_tile.sv */
module exec_tile import tile_pkg::*; #(
  parameter int ROB_DEPTH = 16
) (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic            i_disp_valid,
  input  op_t             i_disp_op,
  input  logic [RD_W-1:0] i_disp_rd,
  input  logic [XLEN-1:0] i_disp_src1,
  input  logic [XLEN-1:0] i_disp_src2,
  output logic            o_cmt_valid,
  output logic [RD_W-1:0] o_cmt_rd,
  output logic [XLEN-1:0] o_cmt_data
);

  localparam int CMT_ID_W = $clog2(ROB_DEPTH);

  // ------------------------------
  // Steering to ROB and units
  // ------------------------------
  logic                w_alloc_valid;
  logic [CMT_ID_W-1:0] w_new_cmt_id;

  logic                w_alu_valid;
  logic [CMT_ID_W-1:0] w_alu_cmt_id;
  logic [RD_W-1:0]     w_alu_rd;
  op_t                 w_alu_op;
  logic [XLEN-1:0]     w_alu_src1;
  logic [XLEN-1:0]     w_alu_src2;

  logic                w_mul_valid;
  logic [CMT_ID_W-1:0] w_mul_cmt_id;
  logic [RD_W-1:0]     w_mul_rd;
  logic [XLEN-1:0]     w_mul_src1;
  logic [XLEN-1:0]     w_mul_src2;

  // ------------------------------
  // Done reports
  // ------------------------------
  logic                w_alu_done_valid;
  logic [CMT_ID_W-1:0] w_alu_done_cmt_id;
  logic [RD_W-1:0]     w_alu_done_rd;
  logic [XLEN-1:0]     w_alu_done_data;

  logic                w_mul_done_valid;
  logic [CMT_ID_W-1:0] w_mul_done_cmt_id;
  logic [RD_W-1:0]     w_mul_done_rd;
  logic [XLEN-1:0]     w_mul_done_data;

  disp_steer #(.CMT_ID_W(CMT_ID_W)) u_disp_steer (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_disp_valid  (i_disp_valid),
    .i_disp_op     (i_disp_op),
    .i_disp_rd     (i_disp_rd),
    .i_disp_src1   (i_disp_src1),
    .i_disp_src2   (i_disp_src2),
    .i_new_cmt_id  (w_new_cmt_id),
    .o_alloc_valid (w_alloc_valid),
    .o_alu_valid   (w_alu_valid),
    .o_alu_cmt_id  (w_alu_cmt_id),
    .o_alu_rd      (w_alu_rd),
    .o_alu_op      (w_alu_op),
    .o_alu_src1    (w_alu_src1),
    .o_alu_src2    (w_alu_src2),
    .o_mul_valid   (w_mul_valid),
    .o_mul_cmt_id  (w_mul_cmt_id),
    .o_mul_rd      (w_mul_rd),
    .o_mul_src1    (w_mul_src1),
    .o_mul_src2    (w_mul_src2)
  );

  alu_unit #(.CMT_ID_W(CMT_ID_W)) u_alu (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_valid       (w_alu_valid),
    .i_cmt_id      (w_alu_cmt_id),
    .i_rd          (w_alu_rd),
    .i_op          (w_alu_op),
    .i_src1        (w_alu_src1),
    .i_src2        (w_alu_src2),
    .o_done_valid  (w_alu_done_valid),
    .o_done_cmt_id (w_alu_done_cmt_id),
    .o_done_rd     (w_alu_done_rd),
    .o_done_data   (w_alu_done_data)
  );

  mul_unit #(.CMT_ID_W(CMT_ID_W)) u_mul (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_valid       (w_mul_valid),
    .i_cmt_id      (w_mul_cmt_id),
    .i_rd          (w_mul_rd),
    .i_src1        (w_mul_src1),
    .i_src2        (w_mul_src2),
    .o_done_valid  (w_mul_done_valid),
    .o_done_cmt_id (w_mul_done_cmt_id),
    .o_done_rd     (w_mul_done_rd),
    .o_done_data   (w_mul_done_data)
  );

  // Port A takes the ALU, port B the multiplier
  rob #(.ROB_DEPTH(ROB_DEPTH), .CMT_ID_W(CMT_ID_W)) u_rob (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_alloc_valid   (w_alloc_valid),
    .o_new_cmt_id    (w_new_cmt_id),
    .i_done_a_valid  (w_alu_done_valid),
    .i_done_a_cmt_id (w_alu_done_cmt_id),
    .i_done_a_rd     (w_alu_done_rd),
    .i_done_a_data   (w_alu_done_data),
    .i_done_b_valid  (w_mul_done_valid),
    .i_done_b_cmt_id (w_mul_done_cmt_id),
    .i_done_b_rd     (w_mul_done_rd),
    .i_done_b_data   (w_mul_done_data),
    .o_cmt_valid     (o_cmt_valid),
    .o_cmt_rd        (o_cmt_rd),
    .o_cmt_data      (o_cmt_data)
  );

endmodule

/* tb_exec_tile.sv */
module tb_exec_tile import tile_pkg::*;;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ALU_CMT_LAT   = 3;
  localparam int MUL_CMT_LAT   = 5;
  localparam int DRAIN_TIMEOUT = 200;
  localparam int NUM_RANDOM    = 2000;

  logic            clk;
  logic            rst;
  logic            disp_valid;
  op_t             disp_op;
  logic [RD_W-1:0] disp_rd;
  logic [XLEN-1:0] disp_src1;
  logic [XLEN-1:0] disp_src2;
  logic            cmt_valid;
  logic [RD_W-1:0] cmt_rd;
  logic [XLEN-1:0] cmt_data;

  // Expected commits in dispatch order
  // A latency of 0 is not checked
  logic [RD_W-1:0] exp_rd_q[$];
  logic [XLEN-1:0] exp_data_q[$];
  int              exp_lat_q[$];
  int              disp_cyc_q[$];

  integer seed;
  int     cycle_cnt;
  string  test_name;

  exec_tile dut (
    .i_clk        (clk),
    .i_rst        (rst),
    .i_disp_valid (disp_valid),
    .i_disp_op    (disp_op),
    .i_disp_rd    (disp_rd),
    .i_disp_src1  (disp_src1),
    .i_disp_src2  (disp_src2),
    .o_cmt_valid  (cmt_valid),
    .o_cmt_rd     (cmt_rd),
    .o_cmt_data   (cmt_data)
  );

  always #2 clk = ~clk;

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED: %s expected 0x%08h actual 0x%08h", what, expected, actual);
      $display("Result: FAILED");
      $fatal(1);
    end
  endtask

  // Reference behavior of each op
  function automatic logic [XLEN-1:0] model_result(input op_t op, input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0] prod;
    logic [XLEN-1:0]   res;
    prod = a * b;
    case (op)
      OP_ADD:  res = a + b;
      OP_SUB:  res = a - b;
      OP_AND:  res = a & b;
      OP_OR:   res = a | b;
      OP_XOR:  res = a ^ b;
      OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP_SLL:  res = a << b[4:0];
      OP_MUL:  res = prod[XLEN-1:0];
      default: res = '0;
    endcase
    return res;
  endfunction

  task automatic dispatch(input op_t op, input logic [RD_W-1:0] rd,
                          input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                          input int lat);
    @(negedge clk);
    disp_valid = 1'b1;
    disp_op    = op;
    disp_rd    = rd;
    disp_src1  = a;
    disp_src2  = b;
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(model_result(op, a, b));
    exp_lat_q.push_back(lat);
    disp_cyc_q.push_back(cycle_cnt);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      disp_valid = 1'b0;
    end
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    idle_cycles(1);
    while (exp_rd_q.size() != 0 && cnt < DRAIN_TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (exp_rd_q.size() != 0) begin
      abort_run($sformatf("Timeout in %s: commits stopped arriving with %0d outstanding",
                          test_name, exp_rd_q.size()));
    end
  endtask

  // ------------------------------
  // Commit monitor
  // ------------------------------
  // Samples the registered commit outputs on the rising edge
  always @(posedge clk) begin
    if (!rst && cmt_valid) begin
      if (exp_rd_q.size() == 0) begin
        abort_run($sformatf("Unexpected commit in %s with nothing outstanding", test_name));
      end else begin
        check_value({test_name, " rd"}, exp_rd_q[0], cmt_rd);
        check_value({test_name, " data"}, exp_data_q[0], cmt_data);
        if (exp_lat_q[0] != 0) begin
          check_value({test_name, " latency"}, exp_lat_q[0], cycle_cnt - disp_cyc_q[0]);
        end
        void'(exp_rd_q.pop_front());
        void'(exp_data_q.pop_front());
        void'(exp_lat_q.pop_front());
        void'(disp_cyc_q.pop_front());
      end
    end
    cycle_cnt = cycle_cnt + 1;
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin
    logic [31:0] rnd;
    op_t         op;
    int          gap;

    clk        = 1'b0;
    rst        = 1'b1;
    disp_valid = 1'b0;
    disp_op    = OP_ADD;
    disp_rd    = '0;
    disp_src1  = '0;
    disp_src2  = '0;
    seed       = 56;
    cycle_cnt  = 0;
    test_name  = "reset";

    repeat (2) @(negedge clk);
    rst = 1'b0;

    // Quiet tile must not commit
    test_name = "idle";
    idle_cycles(10);

    // Each ALU op alone with random and edge operands
    test_name = "single_alu";
    for (int i = 0; i <= int'(OP_SLL); i++) begin
      op = op_t'(i);
      dispatch(op, 5'(i + 1), $random(seed), $random(seed), ALU_CMT_LAT);
      wait_drain();
      dispatch(op, 5'(i + 9), 32'h8000_0001, 32'hffff_ff21, ALU_CMT_LAT);
      wait_drain();
    end

    test_name = "single_mul";
    dispatch(OP_MUL, 5'd3, 32'h1234_5678, 32'h9abc_def0, MUL_CMT_LAT);
    wait_drain();
    dispatch(OP_MUL, 5'd4, 32'hffff_fffd, 32'h0000_0007, MUL_CMT_LAT);
    wait_drain();
    dispatch(OP_MUL, 5'd5, $random(seed), $random(seed), MUL_CMT_LAT);
    wait_drain();

    // ALU results finish before the older multiply
    test_name = "mul_then_alu";
    dispatch(OP_MUL, 5'd10, 32'd1000, 32'd3000, 0);
    dispatch(OP_ADD, 5'd11, 32'd1, 32'd2, 0);
    dispatch(OP_XOR, 5'd12, 32'hf0f0_f0f0, 32'h0ff0_0ff0, 0);
    dispatch(OP_SLT, 5'd13, 32'hffff_fff0, 32'd4, 0);
    dispatch(OP_SLL, 5'd14, 32'h0000_0003, 32'd30, 0);
    dispatch(OP_MUL, 5'd15, 32'd7, 32'd9, 0);
    dispatch(OP_SUB, 5'd16, 32'd5, 32'd9, 0);
    wait_drain();

    test_name = "random";
    for (int n = 0; n < NUM_RANDOM; n++) begin
      rnd = $random(seed);
      op  = op_t'(rnd[2:0]);
      dispatch(op, rnd[7:3], $random(seed), $random(seed), 0);
      rnd = $random(seed);
      // Mostly back to back with an occasional short gap
      if (rnd[1:0] == 2'd0) begin
        gap = 1 + (rnd[7:4] % 6);
        idle_cycles(gap);
      end
    end
    wait_drain();

    idle_cycles(5);
    $display("Result: PASSED");
    $finish;
  end

endmodule

/* src.f */
tile_pkg.sv
stage_pipe.sv
disp_steer.sv
alu_unit.sv
mul_unit.sv
rob.sv
exec_tile.sv
tb_exec_tile.sv

/* Bender.yml */
package:
  name: exec_tile

sources:
  - files:
      - tile_pkg.sv
      - stage_pipe.sv
      - disp_steer.sv
      - alu_unit.sv
      - mul_unit.sv
      - rob.sv
      - exec_tile.sv
  - target: test
    files:
      - tb_exec_tile.sv
